/* Bender.yml */
package:
  name: blit_wdata

sources:
  - common/blit_pkg.sv
  - rtl/blit_logic_unit.sv
  - rtl/blit_regs.sv
  - data_mux/blit_mask_gen.sv
  - data_mux/data_mux.sv
  - rtl/blit_wdata_path.sv
  - target: test
    files:
      - bench/blit_wdata_tb.sv

/* bench/blit_wdata_tb.sv */
// Table-driven testbench for the blitter write-data path with a reference model
`timescale 1ns/1ps

module blit_wdata_tb
	import blit_pkg::*;
();

	localparam int timeout_cycles = 200;
	localparam int row_max = 32;

	logic                  clk;
	logic                  arst_n;
	logic                  cfg_we;
	cfg_addr_e             cfg_addr;
	logic [cfg_data_w-1:0] cfg_wdata;
	logic                  in_valid;
	logic                  in_ready;
	phrase_in_t            in_phrase;
	logic                  out_valid;
	logic                  out_ready;
	phrase_out_t           out_phrase;

	int          error_count = 0;
	int          check_count = 0;
	int          cycle = 0;
	int          sent_count = 0;
	int          out_count = 0;
	// Random out_ready during bursts
	logic        ready_toggle;
	logic [31:0] rng_state;
	// Outstanding phrases in acceptance order
	// A tag of -1 marks a burst phrase
	logic [phrase_w-1:0] exp_q[$];
	int                  tag_q[$];
	int                  acc_q[$];
	// Stimulus table
	string       row_name[row_max];
	data_sel_e   row_sel[row_max];
	logic [3:0]  row_func[row_max];
	logic [63:0] row_pat[row_max];
	logic [5:0]  row_dstart[row_max];
	logic [5:0]  row_dend[row_max];
	logic [7:0]  row_binh[row_max];
	int          row_count = 0;

	blit_wdata_path blit_wdata_path_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_phrase  (in_phrase),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_phrase (out_phrase)
	);

	always #2 clk = ~clk;

	// Edge counter read at the falling edge only
	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [31:0] rand32();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Bit i of byte 0, then bit 8k standing for byte k
	function automatic logic [14:0] expected_mask(input int ds, input int de,
		input logic [7:0] binh);
		logic [14:0] m;
		for (int i = 0; i < 8; i++) begin
			m[i] = (ds <= i) && (de == 0 || i < de) && binh[0];
		end
		for (int k = 1; k < 8; k++) begin
			m[7+k] = (ds <= 8*k) && (de == 0 || 8*k < de) && binh[k];
		end
		return m;
	endfunction

	// Truth table indexed by {source bit, destination bit}
	function automatic logic [63:0] lfu_model(input logic [3:0] func, input logic [63:0] s,
		input logic [63:0] d);
		logic [63:0] r;
		for (int i = 0; i < 64; i++) begin
			r[i] = func[{s[i], d[i]}];
		end
		return r;
	endfunction

	function automatic logic [63:0] expected_wdata(input data_sel_e sel,
		input logic [3:0] func, input logic [63:0] pat, input phrase_in_t p);
		logic [14:0] m;
		logic [63:0] nd;
		logic [63:0] od;
		logic [63:0] w;
		m = expected_mask(p.dstart, p.dend, p.dbinh_n);
		case (sel)
			sel_patd: nd = pat;
			sel_lfu:  nd = lfu_model(func, p.srcd, p.dstd);
			sel_addq: nd = p.addq;
			default:  nd = p.srcz;
		endcase
		// Z mode keeps destination Z, never destination data
		od = (sel == sel_zed) ? p.dstz : p.dstd;
		for (int i = 0; i < 8; i++) begin
			w[i] = m[i] ? nd[i] : od[i];
		end
		for (int k = 1; k < 8; k++) begin
			w[8*k +: 8] = m[7+k] ? nd[8*k +: 8] : od[8*k +: 8];
		end
		return w;
	endfunction

	function phrase_in_t make_phrase(input logic [5:0] ds, input logic [5:0] de,
		input logic [7:0] binh);
		phrase_in_t p;
		p.srcd = {rand32(), rand32()};
		p.dstd = {rand32(), rand32()};
		p.srcz = {rand32(), rand32()};
		p.dstz = {rand32(), rand32()};
		// Four 16-bit adder lanes
		p.addq = {rand32(), rand32()};
		p.dstart = ds;
		p.dend = de;
		p.dbinh_n = binh;
		return p;
	endfunction

	task check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Error %s expected %h actual %h", name, exp, act);
		end
	endtask

	task finish_run();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	// Next drive point 1 ns after the rising edge
	task tick();
		logic [31:0] r;
		logic        exp_rdy;
		@(posedge clk);
		#1;
		// Input refused only with both stages full and the output stalled
		exp_rdy = (exp_q.size() < 2) || out_ready;
		check_value("in_ready", {63'd0, exp_rdy}, {63'd0, in_ready});
		if (ready_toggle) begin
			r = rand32();
			out_ready = r[0];
		end
	endtask

	task write_reg(input cfg_addr_e addr, input logic [31:0] data);
		tick();
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
	endtask

	task write_cfg(input data_sel_e sel, input logic [3:0] func, input logic [63:0] pat);
		write_reg(reg_pat_lo, pat[31:0]);
		write_reg(reg_pat_hi, pat[63:32]);
		write_reg(reg_ctrl, {24'd0, func, 2'd0, sel});
		tick();
		cfg_we = 1'b0;
	endtask

	// Holds the phrase until in_ready is seen high before an edge
	task automatic send_phrase(input phrase_in_t p, input logic [63:0] exp, input int tag);
		int t;
		logic taken;
		t = 0;
		taken = 1'b0;
		in_valid = 1'b1;
		in_phrase = p;
		while (!taken) begin
			@(negedge clk);
			if (in_ready) begin
				taken = 1'b1;
				exp_q.push_back(exp);
				tag_q.push_back(tag);
				acc_q.push_back(cycle);
				sent_count++;
			end else if (t >= timeout_cycles) begin
				error_count++;
				$display("Timeout: in_ready stayed low for %0d cycles", t);
				finish_run();
			end
			t++;
			tick();
		end
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while (exp_q.size() != 0) begin
			if (t >= timeout_cycles) begin
				error_count++;
				$display("Timeout: %0d phrases never came out", exp_q.size());
				finish_run();
			end
			tick();
			t++;
		end
	endtask

	task add_row(input string name, input data_sel_e sel, input logic [3:0] func,
		input logic [63:0] pat, input logic [5:0] ds, input logic [5:0] de,
		input logic [7:0] binh);
		row_name[row_count] = name;
		row_sel[row_count] = sel;
		row_func[row_count] = func;
		row_pat[row_count] = pat;
		row_dstart[row_count] = ds;
		row_dend[row_count] = de;
		row_binh[row_count] = binh;
		row_count++;
	endtask

	task automatic run_row(input int i);
		phrase_in_t p;
		write_cfg(row_sel[i], row_func[i], row_pat[i]);
		p = make_phrase(row_dstart[i], row_dend[i], row_binh[i]);
		send_phrase(p, expected_wdata(row_sel[i], row_func[i], row_pat[i], p), i);
		in_valid = 1'b0;
		wait_drain();
	endtask

	// Fixed config, random phrases back to back, out_ready from the random stream
	task automatic run_burst(input int n);
		data_sel_e   sel;
		logic [3:0]  func;
		logic [63:0] pat;
		logic [31:0] r;
		phrase_in_t  p;
		r = rand32();
		sel = data_sel_e'(r[1:0]);
		func = r[7:4];
		pat = {rand32(), rand32()};
		write_cfg(sel, func, pat);
		ready_toggle = 1'b1;
		for (int i = 0; i < n; i++) begin
			r = rand32();
			p = make_phrase(r[5:0], r[11:6], r[19:12] | r[27:20]);
			send_phrase(p, expected_wdata(sel, func, pat, p), -1);
		end
		in_valid = 1'b0;
		wait_drain();
		ready_toggle = 1'b0;
		out_ready = 1'b1;
	endtask

	// Output transfers seen before the edge that completes them
	always @(negedge clk) begin : watch_output
		logic [63:0] exp;
		int          tag;
		int          lat;
		string       name;
		if (arst_n && out_valid && out_ready) begin
			out_count++;
			if (exp_q.size() == 0) begin
				error_count++;
				$display("An output phrase appeared with no phrase outstanding");
			end else begin
				exp = exp_q.pop_front();
				tag = tag_q.pop_front();
				lat = cycle - acc_q.pop_front();
				name = (tag < 0) ? "burst" : row_name[tag];
				check_value(name, exp, out_phrase.wdata);
				if (tag >= 0) begin
					check_value({name, "_latency"}, 64'd2, 64'(lat));
				end else if (lat < 2) begin
					error_count++;
					$display("A burst phrase came out after %0d cycles, sooner than 2", lat);
				end
			end
		end
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = reg_pat_lo;
		cfg_wdata = '0;
		in_valid = 1'b0;
		in_phrase = '0;
		out_ready = 1'b1;
		ready_toggle = 1'b0;
		rng_state = 32'hb347_e2c7;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		check_value("reset_out_valid", 64'd0, {63'd0, out_valid});
		check_value("reset_in_ready", 64'd1, {63'd0, in_ready});
		// Name, select, function, pattern, start, end, inhibit
		add_row("reset_zero_pat", sel_patd, 4'h0, 64'h0, 6'd0, 6'd0, 8'hff);
		add_row("pat_full", sel_patd, 4'h0, 64'hdead_beef_0123_4567, 6'd0, 6'd0, 8'hff);
		add_row("pat_inhibit_all", sel_patd, 4'h0, 64'h5a5a_c3c3_f00f_1234, 6'd0, 6'd0, 8'h00);
		add_row("pat_byte0_bits", sel_patd, 4'h0, 64'hffff_ffff_ffff_ffff, 6'd2, 6'd6, 8'hff);
		add_row("pat_end_byte0", sel_patd, 4'h0, 64'h0, 6'd0, 6'd3, 8'hff);
		add_row("pat_bytes_span", sel_patd, 4'h0, 64'h1122_3344_5566_7788, 6'd16, 6'd48, 8'hff);
		add_row("pat_byte0_to_mid", sel_patd, 4'h0, 64'h8877_6655_4433_2211, 6'd5, 6'd40, 8'hff);
		add_row("pat_inhibit_some", sel_patd, 4'h0, 64'hcafe_f00d_beef_babe, 6'd0, 6'd0, 8'ha5);
		add_row("lfu_copy", sel_lfu, 4'b1100, 64'h0, 6'd0, 6'd0, 8'hff);
		add_row("lfu_xor", sel_lfu, 4'b0110, 64'h0, 6'd0, 6'd0, 8'hff);
		add_row("lfu_and", sel_lfu, 4'b1000, 64'h0, 6'd0, 6'd0, 8'hff);
		add_row("lfu_not_dst", sel_lfu, 4'b0101, 64'h0, 6'd0, 6'd0, 8'hff);
		add_row("lfu_one", sel_lfu, 4'b1111, 64'h0, 6'd4, 6'd52, 8'hff);
		add_row("addq_write", sel_addq, 4'h0, 64'h0, 6'd3, 6'd0, 8'hff);
		add_row("zed_full", sel_zed, 4'h0, 64'h0, 6'd0, 6'd0, 8'hff);
		add_row("zed_partial", sel_zed, 4'b1111, 64'hffff_ffff_ffff_ffff, 6'd8, 6'd24, 8'hf7);
		for (int i = 0; i < row_count; i++) begin
			run_row(i);
		end
		for (int b = 0; b < 3; b++) begin
			run_burst(16);
		end
		repeat (4) tick();
		check_value("phrase_count", 64'(sent_count), 64'(out_count));
		finish_run();
	end

endmodule

/* blit_wdata.f */
common/blit_pkg.sv
rtl/blit_logic_unit.sv
rtl/blit_regs.sv
data_mux/blit_mask_gen.sv
data_mux/data_mux.sv
rtl/blit_wdata_path.sv
bench/blit_wdata_tb.sv

/* common/blit_pkg.sv */
// Blitter write-data path package with phrase widths, register map, select codes and bundles
package blit_pkg;

	// One memory phrase
	localparam int phrase_w = 64;
	localparam int byte_w = 8;
	localparam int bytes_n = phrase_w / byte_w;

	// Write mask, eight fine bits for byte 0 then one bit per byte 1 to 7
	localparam int mask_w = 15;

	// Bit position within a phrase, used for start and end pixel
	localparam int pos_w = 6;

	// Per-byte inhibit, active low
	localparam int inh_w = bytes_n;

	// Logic function truth table, indexed by {source bit, destination bit}
	localparam int lfu_w = 4;

	// Configuration port data width
	localparam int cfg_data_w = 32;

	// Write data source
	typedef enum logic [1:0] {
		sel_patd = 2'd0,
		sel_lfu  = 2'd1,
		sel_addq = 2'd2,
		// Source Z merged into destination Z
		sel_zed  = 2'd3
	} data_sel_e;

	// Configuration register addresses
	typedef enum logic [1:0] {
		reg_pat_lo = 2'd0,
		reg_pat_hi = 2'd1,
		// data_sel in bits 1:0, lfu_func in bits 7:4
		reg_ctrl   = 2'd2
	} cfg_addr_e;

	// Register block contents
	typedef struct packed {
		logic [phrase_w-1:0] pattern;
		data_sel_e           data_sel;
		logic [lfu_w-1:0]    lfu_func;
	} blit_cfg_t;

	// One phrase to merge
	typedef struct packed {
		// Source and destination data
		logic [phrase_w-1:0] srcd;
		logic [phrase_w-1:0] dstd;
		// Source and destination Z
		logic [phrase_w-1:0] srcz;
		logic [phrase_w-1:0] dstz;
		// Four 16-bit adder outputs, lane 0 in the low bits
		logic [phrase_w-1:0] addq;
		// First bit written
		logic [pos_w-1:0]    dstart;
		// One past the last bit written, zero runs to the end
		logic [pos_w-1:0]    dend;
		// Zero protects the byte
		logic [inh_w-1:0]    dbinh_n;
	} phrase_in_t;

	// Merged phrase headed for memory
	typedef struct packed {
		logic [phrase_w-1:0] wdata;
	} phrase_out_t;

endpackage

/* data_mux/blit_mask_gen.sv */
// Write mask decode from start and end pixel positions and byte inhibits
`timescale 1ns/1ps

module blit_mask_gen
	import blit_pkg::*;
(
	input  logic [pos_w-1:0]  dstart,
	input  logic [pos_w-1:0]  dend,
	input  logic [inh_w-1:0]  dbinh_n,
	output logic [mask_w-1:0] mask
);

	// Start and end hits for the bits of byte 0
	logic [byte_w-1:0]  s_fine;
	logic [byte_w-1:0]  e_fine;
	// Start and end hits for bytes 1 to 7
	logic [bytes_n-1:1] s_coarse;
	logic [bytes_n-1:1] e_coarse;
	// Running chain across the 15 mask positions
	logic [mask_w-1:0]  started;
	logic [mask_w-1:0]  ended;
	logic [mask_w-1:0]  span;

	// Fine decode only when the position lies in byte 0
	assign s_fine = (dstart[pos_w-1:3] == '0) ? (byte_w'(1) << dstart[2:0]) : '0;
	// End of zero never hits, it means run to the end
	assign e_fine = (dend[pos_w-1:3] == '0) ? (byte_w'(1) << dend[2:0]) & ~byte_w'(1) : '0;

	// Byte k covers bit 8k, so a hit falls in (8k-8, 8k]
	always_comb begin
		for (int k = 1; k < bytes_n; k++) begin
			s_coarse[k] = (dstart > pos_w'(byte_w * (k - 1))) &&
				(dstart <= pos_w'(byte_w * k));
			e_coarse[k] = (dend > pos_w'(byte_w * (k - 1))) &&
				(dend <= pos_w'(byte_w * k));
		end
	end

	// Once started stays started, once ended stays ended
	always_comb begin
		started[0] = s_fine[0];
		ended[0] = e_fine[0];
		// Bits 1 to 7 of byte 0
		for (int i = 1; i < byte_w; i++) begin
			started[i] = started[i-1] | s_fine[i];
			ended[i] = ended[i-1] | e_fine[i];
		end
		// Whole bytes 1 to 7 continue the same chain
		for (int k = 1; k < bytes_n; k++) begin
			started[byte_w-1+k] = started[byte_w-2+k] | s_coarse[k];
			ended[byte_w-1+k] = ended[byte_w-2+k] | e_coarse[k];
		end
	end

	// Inside the span when started and not yet ended
	assign span = started & ~ended;

	// Byte 0 inhibit clears all eight fine bits
	assign mask[byte_w-1:0] = dbinh_n[0] ? span[byte_w-1:0] : '0;

	// Upper bytes inhibit one mask bit each
	assign mask[mask_w-1:byte_w] = span[mask_w-1:byte_w] & dbinh_n[inh_w-1:1];

endmodule

/* data_mux/data_mux.sv */
// Write source select and masked merge with destination data
`timescale 1ns/1ps

module data_mux
	import blit_pkg::*;
(
	input  blit_cfg_t            cfg,
	input  logic [phrase_w-1:0]  lfu_data,
	input  phrase_in_t           phrase,
	input  logic [mask_w-1:0]    mask,
	output logic [phrase_w-1:0]  wdata
);

	// Candidate new data
	logic [phrase_w-1:0] ddat;
	// Data kept where the mask is clear
	logic [phrase_w-1:0] odat;
	// Z mode swaps both sides of the merge
	logic                zed_sel;

	assign zed_sel = (cfg.data_sel == sel_zed);

	// Source select
	always_comb begin
		unique case (cfg.data_sel)
			sel_patd: ddat = cfg.pattern;
			sel_lfu:  ddat = lfu_data;
			// Adder lanes already packed lane 0 lowest
			sel_addq: ddat = phrase.addq;
			sel_zed:  ddat = phrase.srcz;
			default:  ddat = '0;
		endcase
	end

	// Destination Z in Z mode, destination data otherwise
	assign odat = zed_sel ? phrase.dstz : phrase.dstd;

	// Byte 0 merges bit by bit
	assign wdata[byte_w-1:0] = (mask[byte_w-1:0] & ddat[byte_w-1:0]) |
		(~mask[byte_w-1:0] & odat[byte_w-1:0]);

	// Bytes 1 to 7 merge whole bytes
	always_comb begin
		for (int k = 1; k < bytes_n; k++) begin
			if (mask[byte_w-1+k]) begin
				wdata[k*byte_w +: byte_w] = ddat[k*byte_w +: byte_w];
			end else begin
				wdata[k*byte_w +: byte_w] = odat[k*byte_w +: byte_w];
			end
		end
	end

endmodule

/* rtl/blit_logic_unit.sv */
// Bitwise boolean function of source and destination from a 4-bit truth table
`timescale 1ns/1ps

module blit_logic_unit
	import blit_pkg::*;
(
	input  logic [lfu_w-1:0]    lfu_func,
	input  logic [phrase_w-1:0] srcd,
	input  logic [phrase_w-1:0] dstd,
	output logic [phrase_w-1:0] lfu_data
);

	// Minterms of each source and destination pair
	logic [phrase_w-1:0] m_nsnd;
	logic [phrase_w-1:0] m_nsd;
	logic [phrase_w-1:0] m_snd;
	logic [phrase_w-1:0] m_sd;

	// Index 0, neither bit set
	assign m_nsnd = ~srcd & ~dstd;
	// Index 1, destination only
	assign m_nsd = ~srcd & dstd;
	// Index 2, source only
	assign m_snd = srcd & ~dstd;
	// Index 3, both set
	assign m_sd = srcd & dstd;

	// Sum of the minterms enabled by the truth table
	// 4'b1100 copies source, 4'b0110 is XOR, 4'b1111 is all ones
	assign lfu_data = ({phrase_w{lfu_func[0]}} & m_nsnd) |
		({phrase_w{lfu_func[1]}} & m_nsd) |
		({phrase_w{lfu_func[2]}} & m_snd) |
		({phrase_w{lfu_func[3]}} & m_sd);

endmodule

/* rtl/blit_regs.sv */
// Configuration registers for pattern, data select and logic function
`timescale 1ns/1ps

module blit_regs
	import blit_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  cfg_we,
	input  cfg_addr_e             cfg_addr,
	input  logic [cfg_data_w-1:0] cfg_wdata,
	output blit_cfg_t             cfg
);

	// Pattern low half
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.pattern[cfg_data_w-1:0] <= '0;
		end else if (cfg_we && cfg_addr == reg_pat_lo) begin
			cfg.pattern[cfg_data_w-1:0] <= cfg_wdata;
		end
	end

	// Pattern high half
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.pattern[phrase_w-1:cfg_data_w] <= '0;
		end else if (cfg_we && cfg_addr == reg_pat_hi) begin
			cfg.pattern[phrase_w-1:cfg_data_w] <= cfg_wdata;
		end
	end

	// Control word with select and function
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.data_sel <= sel_patd;
			cfg.lfu_func <= '0;
		end else if (cfg_we) begin
			case (cfg_addr)
				reg_ctrl: begin
					cfg.data_sel <= data_sel_e'(cfg_wdata[1:0]);
					cfg.lfu_func <= cfg_wdata[7:4];
				end
				// Address 3 and the pattern halves leave control alone
				default: begin
					cfg.data_sel <= cfg.data_sel;
					cfg.lfu_func <= cfg.lfu_func;
				end
			endcase
		end
	end

	// A control write with an undefined select would poison every later phrase
	ctrl_sel_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		(cfg_we && cfg_addr == reg_ctrl) |-> !$isunknown(cfg_wdata[1:0])
	) else $error("reg_ctrl write with unknown data_sel");

endmodule

/* rtl/blit_wdata_path.sv */
// Write-data path top, two-stage valid/ready pipeline around mask, logic unit and mux
`timescale 1ns/1ps

module blit_wdata_path
	import blit_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  cfg_we,
	input  cfg_addr_e             cfg_addr,
	input  logic [cfg_data_w-1:0] cfg_wdata,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  phrase_in_t            in_phrase,
	output logic                  out_valid,
	input  logic                  out_ready,
	output phrase_out_t           out_phrase
);

	blit_cfg_t           cfg;
	// Stage 1 holds the raw phrase
	logic                s1_valid;
	logic                s1_ready;
	phrase_in_t          s1_phrase;
	// Stage 2 holds the merged phrase
	logic                s2_valid;
	logic                s2_ready;
	phrase_out_t         s2_phrase;
	// Combinational results on stage 1
	logic [mask_w-1:0]   mask;
	logic [phrase_w-1:0] lfu_data;
	logic [phrase_w-1:0] wdata;

	blit_regs blit_regs_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg       (cfg)
	);

	blit_mask_gen blit_mask_gen_inst (
		.dstart  (s1_phrase.dstart),
		.dend    (s1_phrase.dend),
		.dbinh_n (s1_phrase.dbinh_n),
		.mask    (mask)
	);

	blit_logic_unit blit_logic_unit_inst (
		.lfu_func (cfg.lfu_func),
		.srcd     (s1_phrase.srcd),
		.dstd     (s1_phrase.dstd),
		.lfu_data (lfu_data)
	);

	data_mux data_mux_inst (
		.cfg      (cfg),
		.lfu_data (lfu_data),
		.phrase   (s1_phrase),
		.mask     (mask),
		.wdata    (wdata)
	);

	// Ready when empty or when the content leaves this cycle
	assign s2_ready = !s2_valid || out_ready;
	assign s1_ready = !s1_valid || s2_ready;
	assign in_ready = s1_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s1_ready) begin
				s1_valid <= in_valid;
			end
			if (s2_ready) begin
				s2_valid <= s1_valid;
			end
		end
	end

	// Payload loads only on a transfer into the stage
	always_ff @(posedge clk) begin
		if (in_valid && s1_ready) begin
			s1_phrase <= in_phrase;
		end
		if (s1_valid && s2_ready) begin
			s2_phrase.wdata <= wdata;
		end
	end

	assign out_valid = s2_valid;
	assign out_phrase = s2_phrase;

	// Held output under back-pressure
	out_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_phrase))
	) else $error("out_valid or out_phrase changed while stalled");

	// Register block select must be defined whenever the mux feeds stage 2
	sel_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		s1_valid |-> !$isunknown(cfg.data_sel)
	) else $error("data_sel unknown with a phrase in stage 1");

endmodule
